// File: common/pkt_stats_pkg.sv
// Widths, sizes and record types of the packet statistics engine
// Beat, counter result, checksum result and report structs

`default_nettype none

package pkt_stats_pkg;

    ////////////////////
    // Sizes

    // Byte lanes per beat
    localparam int data_bytes = 4;
    localparam int data_w     = data_bytes * 8;

    localparam int dest_w     = 2;
    localparam int num_dest   = 1 << dest_w;

    // Up to 4095 bytes per packet
    localparam int len_w      = 12;
    localparam int seq_w      = 8;
    localparam int csum_w     = 16;

    // Report queue
    localparam int fifo_depth   = 4;
    localparam int fifo_ptr_w   = $clog2(fifo_depth);
    // Entries kept free so that one report in flight always fits
    localparam int fifo_reserve = 2;

    ////////////////////
    // Records

    // One accepted input beat
    typedef struct packed {
        logic [data_w-1:0]     data;
        logic [data_bytes-1:0] keep;
        logic                  last;
        logic [dest_w-1:0]     dest;
    } beat_t;

    // Byte counter result
    typedef struct packed {
        logic [len_w-1:0] byte_len;
        logic             keep_err;
    } count_res_t;

    // Checksum result, not inverted
    typedef struct packed {
        logic [csum_w-1:0] csum;
    } sum_res_t;

    // One packet report, 39 bits
    typedef struct packed {
        logic [dest_w-1:0] dest;
        logic [seq_w-1:0]  seq;
        logic [len_w-1:0]  byte_len;
        logic [csum_w-1:0] csum;
        logic              keep_err;
    } report_t;

endpackage

`default_nettype wire

// File: logic/byte_counter.sv
// Per-packet byte counter with keep pattern check

`default_nettype none
`timescale 1ns/1ps

module byte_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      accept,
    input  pkt_stats_pkg::beat_t      beat,
    output logic                      done,
    output pkt_stats_pkg::count_res_t res
);

    ////////////////////
    // Helpers

    // Number of kept lanes, widened to the length width
    function automatic logic [pkt_stats_pkg::len_w-1:0] keep_bytes(
        input logic [pkt_stats_pkg::data_bytes-1:0] keep
    );
        logic [pkt_stats_pkg::len_w-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < pkt_stats_pkg::data_bytes; i++) begin
            cnt = cnt + pkt_stats_pkg::len_w'(keep[i]);
        end
        return cnt;
    endfunction

    // Last beat keep must be non-zero and packed from lane 0
    function automatic logic last_keep_ok(
        input logic [pkt_stats_pkg::data_bytes-1:0] keep
    );
        logic [pkt_stats_pkg::data_bytes-1:0] nxt;
        nxt = keep + 1'b1;
        return (keep != '0) && ((keep & nxt) == '0);
    endfunction

    logic [pkt_stats_pkg::len_w-1:0] len_acc;
    logic                            err_acc;
    logic [pkt_stats_pkg::len_w-1:0] len_sum;
    logic                            beat_err;
    logic                            err_sum;

    always_comb begin
        len_sum  = len_acc + keep_bytes(beat.keep);
        // Middle beats carry all lanes
        beat_err = beat.last ? !last_keep_ok(beat.keep) : (beat.keep != '1);
        err_sum  = err_acc | beat_err;
    end

    ////////////////////
    // Running state

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            len_acc <= '0;
            err_acc <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= accept && beat.last;
            if (accept) begin
                if (beat.last) begin
                    len_acc <= '0;
                    err_acc <= 1'b0;
                end else begin
                    len_acc <= len_sum;
                    err_acc <= err_sum;
                end
            end
        end
    end

    // Result held until the next packet closes
    always_ff @(posedge clk) begin
        if (accept && beat.last) begin
            res.byte_len <= len_sum;
            res.keep_err <= err_sum;
        end
    end

endmodule

`default_nettype wire

// File: logic/sum16_accumulator.sv
// Ones' complement 16-bit checksum over kept byte lanes of each packet

`default_nettype none
`timescale 1ns/1ps

module sum16_accumulator (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    accept,
    input  pkt_stats_pkg::beat_t    beat,
    output logic                    done,
    output pkt_stats_pkg::sum_res_t res
);

    localparam int cw = pkt_stats_pkg::csum_w;

    logic [pkt_stats_pkg::data_w-1:0] masked;
    logic [cw-1:0]                    word_lo;
    logic [cw-1:0]                    word_hi;
    logic [cw+1:0]                    raw_sum;
    logic [cw:0]                      fold_1;
    logic [cw-1:0]                    sum_next;
    logic [cw-1:0]                    acc;

    ////////////////////
    // Lane masking and word forming

    always_comb begin
        for (int i = 0; i < pkt_stats_pkg::data_bytes; i++) begin
            masked[i*8 +: 8] = beat.keep[i] ? beat.data[i*8 +: 8] : 8'h00;
        end
        // Big-endian pairs, lane 0 is the high byte
        word_lo = {masked[7:0], masked[15:8]};
        word_hi = {masked[23:16], masked[31:24]};
    end

    // Three operands, then fold the carries back in twice
    always_comb begin
        raw_sum  = {2'b00, acc} + {2'b00, word_lo} + {2'b00, word_hi};
        fold_1   = {1'b0, raw_sum[cw-1:0]} + {{(cw-1){1'b0}}, raw_sum[cw+1:cw]};
        // A second carry leaves a tiny low part, so one more add ends it
        sum_next = fold_1[cw-1:0] + {{(cw-1){1'b0}}, fold_1[cw]};
    end

    ////////////////////
    // Running sum

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc  <= '0;
            done <= 1'b0;
        end else begin
            done <= accept && beat.last;
            if (accept) begin
                acc <= beat.last ? '0 : sum_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && beat.last) begin
            res.csum <= sum_next;
        end
    end

endmodule

`default_nettype wire

// File: report_merge/report_merge.sv
// Report merger: joins counter and checksum results with dest and sequence number
// Also drives input ready from the report queue occupancy

`default_nettype none
`timescale 1ns/1ps

module report_merge (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      accept,
    input  pkt_stats_pkg::beat_t      beat,
    input  logic                      cnt_done,
    input  pkt_stats_pkg::count_res_t cnt_res,
    input  logic                      sum_done,
    input  pkt_stats_pkg::sum_res_t   sum_res,
    input  logic [2:0]                fifo_count,
    output logic                      in_ready,
    output logic                      push,
    output pkt_stats_pkg::report_t    push_rpt
);

    localparam int nd = pkt_stats_pkg::num_dest;

    // Destination of the packet whose results are due next
    logic [pkt_stats_pkg::dest_w-1:0] dest_q;

    // One sequence counter per destination
    logic [pkt_stats_pkg::seq_w-1:0]  seq_q [nd];

    logic [2:0]                       fifo_free;

    ////////////////////
    // Destination capture

    // The last beat carries the packet destination
    always_ff @(posedge clk) begin
        if (accept && beat.last) begin
            dest_q <= beat.dest;
        end
    end

    ////////////////////
    // Report build

    // Both counters pulse in the same cycle
    assign push = cnt_done && sum_done;

    always_comb begin
        push_rpt.dest     = dest_q;
        push_rpt.seq      = seq_q[dest_q];
        push_rpt.byte_len = cnt_res.byte_len;
        push_rpt.csum     = sum_res.csum;
        push_rpt.keep_err = cnt_res.keep_err;
    end

    // Advance only the counter of the destination just reported
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int d = 0; d < nd; d++) begin
                seq_q[d] <= '0;
            end
        end else if (push) begin
            seq_q[dest_q] <= seq_q[dest_q] + 1'b1;
        end
    end

    ////////////////////
    // Input flow control

    // At most one report is between accept and push, so two free
    // entries are enough to absorb it
    always_comb begin
        fifo_free = 3'(pkt_stats_pkg::fifo_depth) - fifo_count;
        in_ready  = (fifo_free >= 3'(pkt_stats_pkg::fifo_reserve));
    end

endmodule

`default_nettype wire

// File: report_merge/report_fifo.sv
// Four-entry report queue with occupancy count

`default_nettype none
`timescale 1ns/1ps

module report_fifo (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   push,
    input  pkt_stats_pkg::report_t push_rpt,
    output logic                   rpt_valid,
    input  logic                   rpt_ready,
    output pkt_stats_pkg::report_t rpt,
    output logic [2:0]             count
);

    logic [pkt_stats_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [pkt_stats_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic                                 pop;

    pkt_stats_pkg::report_t mem [pkt_stats_pkg::fifo_depth];

    assign rpt_valid = (count != 3'd0);
    assign pop       = rpt_valid && rpt_ready;
    // Head entry shown directly
    assign rpt       = mem[rd_ptr];

    ////////////////////
    // Pointers and count

    // Pointers wrap on their own at a power-of-two depth
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 3'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_rpt;
        end
    end

endmodule

`default_nettype wire

// File: logic/pkt_stats_top.sv
// Packet statistics engine top level
// Byte counter and checksum side by side, merged into a report queue

`default_nettype none
`timescale 1ns/1ps

module pkt_stats_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  pkt_stats_pkg::beat_t   in_beat,
    output logic                   rpt_valid,
    input  logic                   rpt_ready,
    output pkt_stats_pkg::report_t rpt
);

    logic                      accept;
    logic                      cnt_done;
    logic                      sum_done;
    logic                      push;
    logic [2:0]                fifo_count;
    pkt_stats_pkg::count_res_t cnt_res;
    pkt_stats_pkg::sum_res_t   sum_res;
    pkt_stats_pkg::report_t    push_rpt;

    // Single accept strobe shared by all consumers
    assign accept = in_valid && in_ready;

    ////////////////////
    // Per-packet counters

    byte_counter byte_counter0 (
        .clk    (clk),
        .arst_n (arst_n),
        .accept (accept),
        .beat   (in_beat),
        .done   (cnt_done),
        .res    (cnt_res)
    );

    sum16_accumulator sum16_accumulator0 (
        .clk    (clk),
        .arst_n (arst_n),
        .accept (accept),
        .beat   (in_beat),
        .done   (sum_done),
        .res    (sum_res)
    );

    ////////////////////
    // Merge and queue

    report_merge report_merge0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .accept     (accept),
        .beat       (in_beat),
        .cnt_done   (cnt_done),
        .cnt_res    (cnt_res),
        .sum_done   (sum_done),
        .sum_res    (sum_res),
        .fifo_count (fifo_count),
        .in_ready   (in_ready),
        .push       (push),
        .push_rpt   (push_rpt)
    );

    report_fifo report_fifo0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_rpt  (push_rpt),
        .rpt_valid (rpt_valid),
        .rpt_ready (rpt_ready),
        .rpt       (rpt),
        .count     (fifo_count)
    );

endmodule

`default_nettype wire

// File: bench/pkt_stats_props.sv
// Assertions on the input and report handshakes, reset state and report latency

`default_nettype none
`timescale 1ns/1ps

module pkt_stats_props (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   in_valid,
    input logic                   in_ready,
    input pkt_stats_pkg::beat_t   in_beat,
    input logic                   rpt_valid,
    input logic                   rpt_ready,
    input pkt_stats_pkg::report_t rpt,
    input logic                   push,
    input logic [2:0]             fifo_count
);

    // Last beat taken with the queue empty and nothing about to be written
    logic start_empty;

    assign start_empty = in_valid && in_ready && in_beat.last && (fifo_count == 3'd0) && !push;

    reset_state: assert property (@(posedge clk) $rose(arst_n) |-> in_ready && !rpt_valid)
        else $error("in_ready low or rpt_valid high when reset lifts");

    rpt_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rpt_valid && !rpt_ready |=> rpt_valid && $stable(rpt))
        else $error("stalled report changed or vanished");

    in_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
        else $error("input beat changed before it was accepted");

    // Written at the end of the done cycle, visible one cycle later
    empty_latency: assert property (@(posedge clk) disable iff (!arst_n)
        $past(start_empty, 2) |-> rpt_valid && !$past(rpt_valid))
        else $error("report did not appear two cycles after the last beat");

    no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> fifo_count < 3'(pkt_stats_pkg::fifo_depth))
        else $error("report written into a full queue");

endmodule

`default_nettype wire

// File: bench/pkt_stats_tb.sv
// Testbench for the packet statistics engine
// Random packets, reference model, report compare tasks and timeout

`default_nettype none
`timescale 1ns/1ps

module pkt_stats_tb;

    localparam int num_pkts       = 200;
    localparam int max_beats      = 64;
    localparam int bad_first      = 100;
    localparam int bad_pkts       = 20;
    localparam int stall_at       = 60;
    localparam int stall_cycles   = 300;
    localparam int timeout_cycles = num_pkts * max_beats * 4 + 1000;

    localparam logic [3:0] gapped_keeps [4] = '{4'h5, 4'h9, 4'hb, 4'hd};

    logic                            clk;
    logic                            arst_n;
    logic                            in_valid;
    logic                            in_ready;
    pkt_stats_pkg::beat_t            in_beat;
    logic                            rpt_valid;
    logic                            rpt_ready;
    pkt_stats_pkg::report_t          rpt;

    pkt_stats_pkg::report_t          exp_q [$];
    pkt_stats_pkg::report_t          exp_rpt;
    logic [pkt_stats_pkg::seq_w-1:0] model_seq [pkt_stats_pkg::num_dest];
    int                              mismatches;
    int                              failures;
    int                              cycles;
    int                              pkts_sent;
    int                              rpts_seen;
    bit                              stall;
    bit                              saw_full;

    pkt_stats_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .rpt_valid (rpt_valid),
        .rpt_ready (rpt_ready),
        .rpt       (rpt)
    );

    bind pkt_stats_top pkt_stats_props props0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .rpt_valid  (rpt_valid),
        .rpt_ready  (rpt_ready),
        .rpt        (rpt),
        .push       (push),
        .fifo_count (fifo_count)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Compare tasks

    task automatic report_check(input string name, input pkt_stats_pkg::report_t exp,
                                input pkt_stats_pkg::report_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic len_check(input string name, input logic [pkt_stats_pkg::len_w-1:0] exp,
                             input logic [pkt_stats_pkg::len_w-1:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic csum_check(input string name,
                              input logic [pkt_stats_pkg::csum_w-1:0] exp,
                              input logic [pkt_stats_pkg::csum_w-1:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    ////////////////////
    // Reference model

    // Ones' complement add with end-around carry
    function automatic logic [15:0] oc_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'd0, s[16]};
    endfunction

    // Builds one packet, queues its expected report, then drives its beats
    task automatic send_packet(input int idx);
        pkt_stats_pkg::beat_t   beats [max_beats];
        pkt_stats_pkg::report_t exp;
        logic [1:0]             dest;
        logic [15:0]            sum;
        logic [7:0]             lane [4];
        int                     n_beats;
        int                     len;
        int                     bad_beat;
        bit                     bad;
        bit                     err;
        bit                     ready_now;
        // Short packets while reports are stalled, so the queue fills
        n_beats  = stall ? 1 + $urandom_range(7) : 1 + $urandom_range(max_beats - 1);
        dest     = 2'($urandom);
        bad      = (idx >= bad_first) && (idx < bad_first + bad_pkts);
        bad_beat = (bad && n_beats > 1 && $urandom_range(1) == 1) ?
                   $urandom_range(n_beats - 2) : -1;
        sum = 16'h0000;
        len = 0;
        err = 1'b0;
        for (int i = 0; i < n_beats; i++) begin
            beats[i].data = $urandom;
            beats[i].dest = dest;
            beats[i].last = (i == n_beats - 1);
            if (!beats[i].last) begin
                beats[i].keep = (i == bad_beat) ? 4'($urandom_range(14)) : 4'hf;
                err = err | (beats[i].keep != 4'hf);
            end else begin
                if (bad && bad_beat < 0) begin
                    beats[i].keep = gapped_keeps[$urandom_range(3)];
                end else begin
                    beats[i].keep = 4'((1 << (1 + $urandom_range(3))) - 1);
                end
                err = err | !(beats[i].keep inside {4'h1, 4'h3, 4'h7, 4'hf});
            end
            for (int j = 0; j < 4; j++) begin
                lane[j] = beats[i].keep[j] ? beats[i].data[j*8 +: 8] : 8'h00;
                len     = len + int'(beats[i].keep[j]);
            end
            sum = oc_add(sum, {lane[0], lane[1]});
            sum = oc_add(sum, {lane[2], lane[3]});
        end
        exp.dest     = dest;
        exp.seq      = model_seq[dest];
        exp.byte_len = pkt_stats_pkg::len_w'(len);
        exp.csum     = sum;
        exp.keep_err = err;
        model_seq[dest]++;
        exp_q.push_back(exp);

        for (int i = 0; i < n_beats; i++) begin
            while ($urandom_range(3) == 0) begin
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_beat  = beats[i];
            // in_ready only moves on rising edges
            do begin
                ready_now = in_ready;
                @(negedge clk);
            end while (!ready_now);
            in_valid = 1'b0;
        end
        pkts_sent++;
    endtask

    ////////////////////
    // Report side

    always @(negedge clk) begin
        if (arst_n) begin
            rpt_ready = stall ? 1'b0 : ($urandom_range(3) != 0);
            if (stall && !in_ready) begin
                saw_full = 1'b1;
            end
            if (rpt_valid && rpt_ready) begin
                if (exp_q.size() == 0) begin
                    failures++;
                    $display("report %0d arrived with no packet to match it", rpts_seen);
                end else begin
                    exp_rpt = exp_q.pop_front();
                    report_check($sformatf("report %0d", rpts_seen), exp_rpt, rpt);
                    len_check($sformatf("report %0d byte_len", rpts_seen),
                              exp_rpt.byte_len, rpt.byte_len);
                    csum_check($sformatf("report %0d csum", rpts_seen), exp_rpt.csum, rpt.csum);
                end
                rpts_seen++;
            end
        end
    end

    // Hold the report port for a while once some packets have gone through
    initial begin
        wait (pkts_sent == stall_at);
        @(negedge clk);
        stall = 1'b1;
        repeat (stall_cycles) @(negedge clk);
        stall = 1'b0;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: reports missing");
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'hfe19));
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        rpt_ready  = 1'b0;
        stall      = 1'b0;
        saw_full   = 1'b0;
        mismatches = 0;
        failures   = 0;
        cycles     = 0;
        pkts_sent  = 0;
        rpts_seen  = 0;
        foreach (model_seq[d]) begin
            model_seq[d] = '0;
        end
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        for (int p = 0; p < num_pkts; p++) begin
            send_packet(p);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (rpt_valid) begin
            failures++;
            $display("a report is still queued after all packets were matched");
        end
        if (!saw_full) begin
            failures++;
            $display("in_ready never fell while reports were held back");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/pkt_stats_pkg.sv
logic/byte_counter.sv
logic/sum16_accumulator.sv
report_merge/report_merge.sv
report_merge/report_fifo.sv
logic/pkt_stats_top.sv
bench/pkt_stats_props.sv
bench/pkt_stats_tb.sv

// File: Makefile
# Verilator build and run of the packet statistics testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pkt_stats_tb \
		-f filelist.f -Mdir obj_dir
	./obj_dir/Vpkt_stats_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log
